// File: hw/chan_params.svh
`ifndef CHAN_PARAMS_SVH
`define CHAN_PARAMS_SVH

// Baseband sample width, two's complement.
`define SAMPLE_W 4

// Sample rate relative to the C/A chip rate.
`define SAMPLES_PER_CHIP 2

// One C/A code period.
`define CODE_LEN 1023

// Integration length, one code period of samples.
`define INT_SAMPLES 2046

// Carrier phase accumulator.
`define PHASE_W 16

// Correlator sums, magnitudes and powers.
`define ACC_W 18
`define MAG_W 17
`define POW_W 35

`endif

// File: hw/sample_pkg.sv
`include "chan_params.svh"

package sample_pkg;

   // One baseband sample.
   typedef struct packed {
      logic signed [`SAMPLE_W-1:0] val;
   } sample_t;

   // Channel setup, taken in one transfer.
   typedef struct packed {
      logic [4:0]          prn;
      logic [`PHASE_W-1:0] doppler;
      logic [9:0]          code_phase;
   } chan_cfg_t;

   // Replica chips, 0 is +1 and 1 is -1.
   typedef struct packed {
      logic early;
      logic prompt;
      logic late;
   } chip_set_t;

endpackage

// File: hw/corr_pkg.sv
`include "chan_params.svh"

package corr_pkg;

   // Complex correlator sum.
   typedef struct packed {
      logic signed [`ACC_W-1:0] i;
      logic signed [`ACC_W-1:0] q;
   } iq_acc_t;

   // Sums of all three replicas at the end of an integration.
   typedef struct packed {
      iq_acc_t early;
      iq_acc_t prompt;
      iq_acc_t late;
   } dump_t;

   // I^2 + Q^2 per replica, raw prompt sums kept for the discriminators.
   typedef struct packed {
      logic [`POW_W-1:0] early;
      logic [`POW_W-1:0] prompt;
      logic [`POW_W-1:0] late;
      iq_acc_t           prompt_iq;
   } power_t;

endpackage

// File: hw/ca_code_gen.sv
`timescale 1ns/1ps
`include "chan_params.svh"

module ca_code_gen (
   input  logic       clk,
   input  logic       i_arst_n,
   input  logic       i_load,
   input  logic [4:0] i_prn,
   input  logic [9:0] i_target,
   input  logic       i_step,
   output logic       o_chip,
   output logic       o_seek_done
);

   // G2 tap pair per PRN, stage numbers minus one.
   localparam logic [7:0] G2_TAPS [32] = '{
      8'h15, 8'h26, 8'h37, 8'h48, 8'h08, 8'h19, 8'h07, 8'h18,
      8'h29, 8'h12, 8'h23, 8'h45, 8'h56, 8'h67, 8'h78, 8'h89,
      8'h03, 8'h14, 8'h25, 8'h36, 8'h47, 8'h58, 8'h02, 8'h35,
      8'h46, 8'h57, 8'h68, 8'h79, 8'h05, 8'h16, 8'h27, 8'h38
   };

   logic [9:0] g1;
   logic [9:0] g2;
   logic [9:0] cnt;
   logic [9:0] target_m1;
   logic [4:0] prn_idx;
   logic [3:0] tap_a;
   logic [3:0] tap_b;
   logic       seeking;
   logic       advance;

   assign {tap_a, tap_b} = G2_TAPS[prn_idx];
   assign o_chip         = g1[9] ^ g2[tap_a] ^ g2[tap_b];
   assign advance        = seeking | i_step;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         g1          <= '1;
         g2          <= '1;
         cnt         <= '0;
         target_m1   <= '0;
         prn_idx     <= '0;
         seeking     <= 1'b0;
         o_seek_done <= 1'b0;
      end else if (i_load) begin
         g1          <= '1;
         g2          <= '1;
         cnt         <= '0;
         prn_idx     <= i_prn - 5'd1;
         target_m1   <= (i_target == 10'd0) ? 10'(`CODE_LEN - 1) : i_target - 10'd1;
         seeking     <= 1'b1;
         o_seek_done <= 1'b0;
      end else begin
         if (advance) begin
            // G1 = 1 + x^3 + x^10, G2 = 1 + x^2 + x^3 + x^6 + x^8 + x^9 + x^10.
            g1  <= {g1[8:0], g1[2] ^ g1[9]};
            g2  <= {g2[8:0], g2[1] ^ g2[2] ^ g2[5] ^ g2[7] ^ g2[8] ^ g2[9]};
            cnt <= (cnt == 10'(`CODE_LEN - 1)) ? 10'd0 : cnt + 10'd1;
         end
         // Last seek step lands on the target chip.
         if (seeking && cnt == target_m1) begin
            seeking     <= 1'b0;
            o_seek_done <= 1'b1;
         end
      end
   end

endmodule

// File: hw/code_phase_feed.sv
`timescale 1ns/1ps
`include "chan_params.svh"

module code_phase_feed (
   input  logic                  clk,
   input  logic                  i_arst_n,
   input  sample_pkg::chan_cfg_t i_cfg,
   input  logic                  i_cfg_valid,
   output logic                  o_cfg_ready,
   input  sample_pkg::sample_t   i_sample,
   input  logic                  i_sample_valid,
   output logic                  o_sample_ready,
   input  logic                  i_bank_ready,
   output sample_pkg::chip_set_t o_chips,
   output sample_pkg::sample_t   o_sample,
   output logic                  o_chip_valid,
   output logic                  o_restart
);
   import sample_pkg::*;

   localparam int SUB_W = $clog2(`SAMPLES_PER_CHIP);
   localparam logic [SUB_W-1:0] SUB_LAST = SUB_W'(`SAMPLES_PER_CHIP - 1);

   logic             cfg_xfer;
   logic             smp_xfer;
   logic             seek_busy;
   logic             seek_done;
   logic             gen_chip;
   logic             gen_step;
   logic             prev_chip;
   logic [SUB_W-1:0] sub_cnt;
   chip_set_t        chips_now;

   assign cfg_xfer       = i_cfg_valid & o_cfg_ready;
   assign smp_xfer       = i_sample_valid & o_sample_ready;
   assign o_cfg_ready    = !seek_busy && !o_chip_valid;
   // A pending configuration wins over samples.
   assign o_sample_ready = seek_done && i_bank_ready && !i_cfg_valid;
   assign o_restart      = cfg_xfer;

   // Generator moves on after the first sample of each chip.
   assign gen_step = smp_xfer && (sub_cnt == '0);

   // Generator output is one sample ahead, prev_chip one chip behind.
   assign chips_now.early  = gen_chip;
   assign chips_now.prompt = (sub_cnt == '0) ? gen_chip : prev_chip;
   assign chips_now.late   = prev_chip;

   ca_code_gen u_ca_code_gen (
      .clk         (clk),
      .i_arst_n    (i_arst_n),
      .i_load      (cfg_xfer),
      .i_prn       (i_cfg.prn),
      .i_target    (i_cfg.code_phase),
      .i_step      (gen_step),
      .o_chip      (gen_chip),
      .o_seek_done (seek_done)
   );

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         seek_busy    <= 1'b0;
         sub_cnt      <= '0;
         prev_chip    <= 1'b0;
         o_chip_valid <= 1'b0;
      end else begin
         if (cfg_xfer)
            seek_busy <= 1'b1;
         else if (seek_done)
            seek_busy <= 1'b0;
         if (cfg_xfer)
            sub_cnt <= '0;
         else if (smp_xfer)
            sub_cnt <= (sub_cnt == SUB_LAST) ? '0 : sub_cnt + 1'b1;
         // Seek steps too, so the chip before the start phase is kept.
         if ((seek_busy && !seek_done) || gen_step)
            prev_chip <= gen_chip;
         o_chip_valid <= smp_xfer;
      end
   end

   always_ff @(posedge clk) begin
      if (smp_xfer) begin
         o_sample <= i_sample;
         o_chips  <= chips_now;
      end
   end

endmodule

// File: hw/correlator_bank.sv
`timescale 1ns/1ps
`include "chan_params.svh"

module correlator_bank (
   input  logic                  clk,
   input  logic                  i_arst_n,
   input  logic                  i_restart,
   input  logic [`PHASE_W-1:0]   i_doppler,
   input  sample_pkg::chip_set_t i_chips,
   input  sample_pkg::sample_t   i_sample,
   input  logic                  i_chip_valid,
   output logic                  o_bank_ready,
   output corr_pkg::dump_t       o_dump,
   output logic                  o_dump_valid,
   input  logic                  i_dump_ready
);
   import sample_pkg::*;
   import corr_pkg::*;

   localparam int WIPE_W = `SAMPLE_W + 3;
   localparam int CNT_W  = $clog2(`INT_SAMPLES);
   localparam logic [CNT_W-1:0] LAST = CNT_W'(`INT_SAMPLES - 1);

   // 8-point carrier, amplitude 3.
   localparam logic signed [2:0] COS_LUT [8] = '{
      3'sd3, 3'sd2, 3'sd0, -3'sd2, -3'sd3, -3'sd2, 3'sd0, 3'sd2
   };
   localparam logic signed [2:0] SIN_LUT [8] = '{
      3'sd0, 3'sd2, 3'sd3, 3'sd2, 3'sd0, -3'sd2, -3'sd3, -3'sd2
   };

   logic [`PHASE_W-1:0]      dopp_q;
   logic [`PHASE_W-1:0]      phase;
   logic [CNT_W-1:0]         cnt;
   logic [2:0]               car_idx;
   logic signed [WIPE_W-1:0] wipe_i;
   logic signed [WIPE_W-1:0] wipe_q;
   chip_set_t                wipe_chips;
   logic                     wipe_valid;
   logic                     wipe_last;
   dump_t                    acc;
   dump_t                    acc_next;

   function automatic logic signed [`ACC_W-1:0] term(input logic chip,
                                                     input logic signed [WIPE_W-1:0] v);
      logic signed [`ACC_W-1:0] ext;
      ext = `ACC_W'(v);
      return chip ? -ext : ext;
   endfunction

   assign car_idx = phase[`PHASE_W-1 -: 3];

   // Hold off only if the next sample would close an integration onto a full dump.
   assign o_bank_ready = !(o_dump_valid &&
                           (i_chip_valid ? (cnt == LAST - 1'b1) : (cnt == LAST)));

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         phase      <= '0;
         cnt        <= '0;
         wipe_valid <= 1'b0;
         wipe_last  <= 1'b0;
      end else if (i_restart) begin
         phase      <= '0;
         cnt        <= '0;
         wipe_valid <= 1'b0;
      end else begin
         wipe_valid <= i_chip_valid;
         if (i_chip_valid) begin
            phase     <= phase + dopp_q;
            wipe_last <= (cnt == LAST);
            cnt       <= (cnt == LAST) ? '0 : cnt + 1'b1;
         end
      end
   end

   // Carrier wipe-off.
   always_ff @(posedge clk) begin
      if (i_restart)
         dopp_q <= i_doppler;
      if (i_chip_valid) begin
         wipe_i     <= i_sample.val * COS_LUT[car_idx];
         wipe_q     <= -(i_sample.val * SIN_LUT[car_idx]);
         wipe_chips <= i_chips;
      end
   end

   always_comb begin
      acc_next.early.i  = acc.early.i + term(wipe_chips.early, wipe_i);
      acc_next.early.q  = acc.early.q + term(wipe_chips.early, wipe_q);
      acc_next.prompt.i = acc.prompt.i + term(wipe_chips.prompt, wipe_i);
      acc_next.prompt.q = acc.prompt.q + term(wipe_chips.prompt, wipe_q);
      acc_next.late.i   = acc.late.i + term(wipe_chips.late, wipe_i);
      acc_next.late.q   = acc.late.q + term(wipe_chips.late, wipe_q);
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         acc          <= '0;
         o_dump_valid <= 1'b0;
      end else begin
         if (wipe_valid && wipe_last)
            o_dump_valid <= 1'b1;
         else if (i_dump_ready)
            o_dump_valid <= 1'b0;
         if (i_restart || (wipe_valid && wipe_last))
            acc <= '0;
         else if (wipe_valid)
            acc <= acc_next;
      end
   end

   always_ff @(posedge clk) begin
      if (wipe_valid && wipe_last)
         o_dump <= acc_next;
   end

endmodule

// File: hw/power_calc.sv
`timescale 1ns/1ps
`include "chan_params.svh"

module power_calc (
   input  logic             clk,
   input  logic             i_arst_n,
   input  corr_pkg::dump_t  i_dump,
   input  logic             i_dump_valid,
   output logic             o_dump_ready,
   output corr_pkg::power_t o_power,
   output logic             o_power_valid,
   input  logic             i_power_ready
);
   import corr_pkg::*;

   dump_t                    dump_q;
   logic                     take;
   logic                     run;
   logic                     busy;
   logic [2:0]               sel;
   logic [2:0]               sel1;
   logic [2:0]               sel2;
   logic                     v1;
   logic                     v2;
   logic signed [`ACC_W-1:0] pick;
   logic [`MAG_W-1:0]        mag_q;
   logic [2*`MAG_W-1:0]      sq_q;
   logic [2*`MAG_W-1:0]      partial;

   function automatic logic [`MAG_W-1:0] mag(input logic signed [`ACC_W-1:0] v);
      return `MAG_W'(v[`ACC_W-1] ? -v : v);
   endfunction

   assign take         = i_dump_valid & o_dump_ready;
   assign o_dump_ready = !busy && !o_power_valid;

   // Sums in squaring order, I before Q.
   always_comb begin
      case (sel)
         3'd0:    pick = dump_q.early.i;
         3'd1:    pick = dump_q.early.q;
         3'd2:    pick = dump_q.prompt.i;
         3'd3:    pick = dump_q.prompt.q;
         3'd4:    pick = dump_q.late.i;
         default: pick = dump_q.late.q;
      endcase
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         run           <= 1'b0;
         busy          <= 1'b0;
         sel           <= '0;
         sel1          <= '0;
         sel2          <= '0;
         v1            <= 1'b0;
         v2            <= 1'b0;
         o_power_valid <= 1'b0;
      end else begin
         if (take) begin
            run  <= 1'b1;
            busy <= 1'b1;
            sel  <= '0;
         end else if (run) begin
            sel <= sel + 3'd1;
            if (sel == 3'd5)
               run <= 1'b0;
         end
         v1   <= run;
         sel1 <= sel;
         v2   <= v1;
         sel2 <= sel1;
         // Late Q^2 closes the result.
         if (v2 && sel2 == 3'd5) begin
            busy          <= 1'b0;
            o_power_valid <= 1'b1;
         end else if (i_power_ready) begin
            o_power_valid <= 1'b0;
         end
      end
   end

   // Abs, shared squarer, then pairwise sum.
   always_ff @(posedge clk) begin
      if (take) begin
         dump_q            <= i_dump;
         o_power.prompt_iq <= i_dump.prompt;
      end
      if (run)
         mag_q <= mag(pick);
      if (v1)
         sq_q <= mag_q * mag_q;
      if (v2) begin
         if (!sel2[0])
            partial <= sq_q;
         else if (sel2[2:1] == 2'd0)
            o_power.early <= `POW_W'(partial) + `POW_W'(sq_q);
         else if (sel2[2:1] == 2'd1)
            o_power.prompt <= `POW_W'(partial) + `POW_W'(sq_q);
         else
            o_power.late <= `POW_W'(partial) + `POW_W'(sq_q);
      end
   end

endmodule

// File: hw/track_channel.sv
`timescale 1ns/1ps

module track_channel (
   input  logic                  clk,
   input  logic                  i_arst_n,
   input  sample_pkg::chan_cfg_t i_cfg,
   input  logic                  i_cfg_valid,
   output logic                  o_cfg_ready,
   input  sample_pkg::sample_t   i_sample,
   input  logic                  i_sample_valid,
   output logic                  o_sample_ready,
   output corr_pkg::power_t      o_power,
   output logic                  o_power_valid,
   input  logic                  i_power_ready
);
   import sample_pkg::*;
   import corr_pkg::*;

   chip_set_t chips;
   sample_t   smp;
   logic      chip_valid;
   logic      restart;
   logic      bank_ready;
   dump_t     dump;
   logic      dump_valid;
   logic      dump_ready;

   code_phase_feed u_code_phase_feed (
      .clk            (clk),
      .i_arst_n       (i_arst_n),
      .i_cfg          (i_cfg),
      .i_cfg_valid    (i_cfg_valid),
      .o_cfg_ready    (o_cfg_ready),
      .i_sample       (i_sample),
      .i_sample_valid (i_sample_valid),
      .o_sample_ready (o_sample_ready),
      .i_bank_ready   (bank_ready),
      .o_chips        (chips),
      .o_sample       (smp),
      .o_chip_valid   (chip_valid),
      .o_restart      (restart)
   );

   // Doppler is latched by the bank on the restart pulse.
   correlator_bank u_correlator_bank (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_restart    (restart),
      .i_doppler    (i_cfg.doppler),
      .i_chips      (chips),
      .i_sample     (smp),
      .i_chip_valid (chip_valid),
      .o_bank_ready (bank_ready),
      .o_dump       (dump),
      .o_dump_valid (dump_valid),
      .i_dump_ready (dump_ready)
   );

   power_calc u_power_calc (
      .clk           (clk),
      .i_arst_n      (i_arst_n),
      .i_dump        (dump),
      .i_dump_valid  (dump_valid),
      .o_dump_ready  (dump_ready),
      .o_power       (o_power),
      .o_power_valid (o_power_valid),
      .i_power_ready (i_power_ready)
   );

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int HALF_PERIOD = 50,
   parameter int RST_CYCLES  = 3
) (
   output logic clk,
   output logic o_arst_n
);

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   // Reset leaves just after an edge.
   initial begin
      o_arst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      #1;
      o_arst_n = 1'b1;
   end

endmodule

// File: tests/tb_track_channel.sv
`timescale 1ns/1ps
`include "chan_params.svh"

module tb_track_channel;
   import sample_pkg::*;
   import corr_pkg::*;

   localparam int N_INT       = `INT_SAMPLES;
   localparam int MAX_SAMPLES = 3 * N_INT;
   // Samples of tests 1 to 5, and the number of configurations.
   localparam int TOTAL_SAMPLES = N_INT + 6 * N_INT + (3 * N_INT + 700) + 3 * N_INT + 2 * N_INT;
   localparam int NUM_CFGS      = 8;
   localparam int LIMIT_CYCLES  = 4 * TOTAL_SAMPLES + 2000 * NUM_CFGS;

   // G2 output stages per PRN, numbered 1 to 10.
   localparam int G2_A [32] = '{2, 3, 4, 5, 1, 2, 1, 2, 3, 2, 3, 5, 6, 7, 8, 9,
                                1, 2, 3, 4, 5, 6, 1, 4, 5, 6, 7, 8, 1, 2, 3, 4};
   localparam int G2_B [32] = '{6, 7, 8, 9, 9, 10, 8, 9, 10, 3, 4, 6, 7, 8, 9, 10,
                                4, 5, 6, 7, 8, 9, 3, 6, 7, 8, 9, 10, 6, 7, 8, 9};
   localparam int COS_TAB [8] = '{3, 2, 0, -2, -3, -2, 0, 2};
   localparam int SIN_TAB [8] = '{0, 2, 3, 2, 0, -2, -3, -2};

   logic      clk;
   logic      arst_n;
   chan_cfg_t cfg;
   logic      cfg_valid;
   logic      cfg_ready;
   sample_t   sample;
   logic      sample_valid;
   logic      sample_ready;
   power_t    power;
   logic      power_valid;
   logic      power_ready;

   logic signed [`SAMPLE_W-1:0] stim [MAX_SAMPLES];
   int        code_tab [`CODE_LEN];
   power_t    exp_q [$];
   power_t    exp_v;
   power_t    last_power;
   int        sent_cnt;
   int        errors;
   int        checks;
   int        tests_failed;
   logic      stop_toggle;
   logic      early_check;

   tb_clock_gen u_tb_clock_gen (
      .clk      (clk),
      .o_arst_n (arst_n)
   );

   track_channel u_track_channel (
      .clk            (clk),
      .i_arst_n       (arst_n),
      .i_cfg          (cfg),
      .i_cfg_valid    (cfg_valid),
      .o_cfg_ready    (cfg_ready),
      .i_sample       (sample),
      .i_sample_valid (sample_valid),
      .o_sample_ready (sample_ready),
      .o_power        (power),
      .o_power_valid  (power_valid),
      .i_power_ready  (power_ready)
   );

   // C/A code straight from the two LFSR definitions.
   task automatic build_code(input int prn);
      int g1 [1:10];
      int g2 [1:10];
      int fb1;
      int fb2;
      for (int s = 1; s <= 10; s++) begin
         g1[s] = 1;
         g2[s] = 1;
      end
      for (int c = 0; c < `CODE_LEN; c++) begin
         code_tab[c] = g1[10] ^ g2[G2_A[prn-1]] ^ g2[G2_B[prn-1]];
         fb1 = g1[3] ^ g1[10];
         fb2 = g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10];
         for (int s = 10; s > 1; s--) begin
            g1[s] = g1[s-1];
            g2[s] = g2[s-1];
         end
         g1[1] = fb1;
         g2[1] = fb2;
      end
   endtask

   // Prompt chip of sample m as +1 or -1.
   function automatic int chip_sign(input int start, input int m);
      int idx;
      if (m < 0)
         idx = (start + `CODE_LEN - 1) % `CODE_LEN;
      else
         idx = (start + m / 2) % `CODE_LEN;
      return (code_tab[idx] == 0) ? 1 : -1;
   endfunction

   function automatic power_t ref_power(input int n0, input int start, input int dopp);
      power_t r;
      longint e_i;
      longint e_q;
      longint p_i;
      longint p_q;
      longint l_i;
      longint l_q;
      int     n;
      int     car;
      int     wi;
      int     wq;
      e_i = 0;
      e_q = 0;
      p_i = 0;
      p_q = 0;
      l_i = 0;
      l_q = 0;
      for (int k = 0; k < N_INT; k++) begin
         n   = n0 + k;
         car = int'((longint'(n) * dopp) % 65536 / 8192);
         wi  = stim[n] * COS_TAB[car];
         wq  = -(stim[n] * SIN_TAB[car]);
         e_i += wi * chip_sign(start, n + 1);
         e_q += wq * chip_sign(start, n + 1);
         p_i += wi * chip_sign(start, n);
         p_q += wq * chip_sign(start, n);
         l_i += wi * chip_sign(start, n - 1);
         l_q += wq * chip_sign(start, n - 1);
      end
      r.early       = `POW_W'(e_i * e_i + e_q * e_q);
      r.prompt      = `POW_W'(p_i * p_i + p_q * p_q);
      r.late        = `POW_W'(l_i * l_i + l_q * l_q);
      r.prompt_iq.i = `ACC_W'(p_i);
      r.prompt_iq.q = `ACC_W'(p_q);
      return r;
   endfunction

   task automatic fill_random(input int count);
      for (int k = 0; k < count; k++)
         stim[k] = `SAMPLE_W'($urandom);
   endtask

   task automatic fill_replica(input int count, input int start);
      for (int k = 0; k < count; k++)
         stim[k] = `SAMPLE_W'(3 * chip_sign(start, k));
   endtask

   task automatic push_expected(input int nint, input int start, input int dopp);
      for (int k = 0; k < nint; k++)
         exp_q.push_back(ref_power(k * N_INT, start, dopp));
   endtask

   task automatic configure(input int prn, input int start, input int dopp);
      logic got;
      cfg.prn        = 5'(prn);
      cfg.doppler    = `PHASE_W'(dopp);
      cfg.code_phase = 10'(start);
      cfg_valid      = 1'b1;
      got            = 1'b0;
      while (!got) begin
         @(negedge clk);
         got = cfg_ready;
         @(posedge clk);
         #1;
      end
      cfg_valid = 1'b0;
      sent_cnt  = 0;
   endtask

   task automatic send_samples(input int count, input int gap_pct);
      logic got;
      int   gap;
      for (int k = 0; k < count; k++) begin
         if (gap_pct > 0 && int'($urandom % 100) < gap_pct) begin
            sample_valid = 1'b0;
            gap = 1 + int'($urandom % 3);
            repeat (gap) @(posedge clk);
            #1;
         end
         sample.val   = stim[sent_cnt];
         sample_valid = 1'b1;
         got          = 1'b0;
         while (!got) begin
            @(negedge clk);
            got = sample_ready;
            @(posedge clk);
            #1;
         end
         sent_cnt++;
      end
      sample_valid = 1'b0;
   endtask

   task automatic drain();
      while (exp_q.size() != 0) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic toggle_ready();
      while (!stop_toggle) begin
         @(posedge clk);
         #1;
         power_ready = 1'($urandom);
      end
      power_ready = 1'b1;
   endtask

   task automatic run_with_random_ready(input int count, input int gap_pct);
      stop_toggle = 1'b0;
      fork
         toggle_ready();
         begin
            send_samples(count, gap_pct);
            drain();
            stop_toggle = 1'b1;
         end
      join
   endtask

   task automatic check_field(input string name, input logic [63:0] exp_val,
                              input logic [63:0] act_val);
      checks++;
      if (act_val !== exp_val) begin
         $display("[FAIL] %s expected %0h got %0h", name, exp_val, act_val);
         errors++;
      end
   endtask

   task automatic report_test(input int num, input string name, input int err_before);
      if (errors == err_before) begin
         $display("test %0d %s: pass", num, name);
      end else begin
         $display("test %0d %s: fail with %0d errors", num, name, errors - err_before);
         tests_failed++;
      end
   endtask

   // Results are taken at the falling edge before the transfer edge.
   always @(negedge clk) begin
      if (arst_n && power_valid && power_ready) begin
         if (exp_q.size() == 0) begin
            $display("A result came out of o_power with no expected value pending");
            errors++;
         end else begin
            exp_v = exp_q.pop_front();
            check_field("o_power.early", 64'(exp_v.early), 64'(power.early));
            check_field("o_power.prompt", 64'(exp_v.prompt), 64'(power.prompt));
            check_field("o_power.late", 64'(exp_v.late), 64'(power.late));
            check_field("o_power.prompt_iq.i", 64'($unsigned(exp_v.prompt_iq.i)),
                        64'($unsigned(power.prompt_iq.i)));
            check_field("o_power.prompt_iq.q", 64'($unsigned(exp_v.prompt_iq.q)),
                        64'($unsigned(power.prompt_iq.q)));
         end
         last_power = power;
      end
      if (early_check && power_valid && sent_cnt < N_INT) begin
         $display("o_power_valid rose after only %0d accepted samples", sent_cnt);
         errors++;
      end
   end

   initial begin
      repeat (LIMIT_CYCLES) @(posedge clk);
      $display("Timeout after %0d cycles, the run did not finish", LIMIT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      int seed_val;
      int err_before;
      int prn;
      int start;
      int dopp;
      seed_val     = int'($urandom(32'h65f2));
      cfg          = '0;
      cfg_valid    = 1'b0;
      sample       = '0;
      sample_valid = 1'b0;
      power_ready  = 1'b1;
      sent_cnt     = 0;
      errors       = 0;
      checks       = 0;
      tests_failed = 0;
      stop_toggle  = 1'b0;
      early_check  = 1'b0;
      wait (arst_n === 1'b1);
      @(posedge clk);
      #1;

      // Clean replica, no carrier.
      err_before = errors;
      build_code(1);
      fill_replica(N_INT, 0);
      push_expected(1, 0, 0);
      configure(1, 0, 0);
      send_samples(N_INT, 0);
      drain();
      if (!(last_power.prompt > last_power.early && last_power.prompt > last_power.late)) begin
         $display("Prompt power is not the largest of the three replicas");
         errors++;
      end
      report_test(1, "replica correlation", err_before);

      err_before = errors;
      for (int c = 0; c < 3; c++) begin
         prn   = 1 + int'($urandom % 32);
         start = int'($urandom % `CODE_LEN);
         dopp  = 1 + int'($urandom % 65535);
         build_code(prn);
         fill_random(2 * N_INT);
         push_expected(2, start, dopp);
         configure(prn, start, dopp);
         run_with_random_ready(2 * N_INT, 0);
      end
      report_test(2, "prn and doppler sweep", err_before);

      // Partial second integration is dropped by the new configuration.
      err_before = errors;
      build_code(7);
      fill_random(N_INT + 700);
      push_expected(1, 300, 4321);
      configure(7, 300, 4321);
      send_samples(N_INT + 700, 0);
      build_code(23);
      fill_random(2 * N_INT);
      push_expected(2, 1022, 60000);
      configure(23, 1022, 60000);
      send_samples(2 * N_INT, 0);
      drain();
      report_test(3, "reconfiguration", err_before);

      err_before = errors;
      build_code(12);
      fill_random(3 * N_INT);
      push_expected(3, 511, 1500);
      configure(12, 511, 1500);
      power_ready = 1'b0;
      fork
         send_samples(3 * N_INT, 0);
         begin
            while (sent_cnt < 3 * N_INT - 1)
               @(posedge clk);
            repeat (100) @(posedge clk);
            if (sent_cnt != 3 * N_INT - 1) begin
               $display("A sample was taken while two results were still pending");
               errors++;
            end
            #1;
            power_ready = 1'b1;
         end
      join
      drain();
      report_test(4, "back-pressure", err_before);

      err_before = errors;
      build_code(31);
      fill_random(2 * N_INT);
      push_expected(2, 77, 9000);
      configure(31, 77, 9000);
      early_check = 1'b1;
      run_with_random_ready(2 * N_INT, 30);
      early_check = 1'b0;
      report_test(5, "input gaps", err_before);

      $display("tests 5, failed %0d, checks %0d, errors %0d", tests_failed, checks, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: sim.f
+incdir+hw
hw/sample_pkg.sv
hw/corr_pkg.sv
hw/ca_code_gen.sv
hw/code_phase_feed.sv
hw/correlator_bank.sv
hw/power_calc.sv
hw/track_channel.sv
tests/tb_clock_gen.sv
tests/tb_track_channel.sv

// File: run_sim.sh
#!/bin/sh
# Builds the tracking channel testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
   --top-module tb_track_channel \
   -f sim.f

./obj_dir/Vtb_track_channel > sim.log 2>&1
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
   echo "Simulation reported a failure, see sim.log"
   exit 1
fi
echo "Simulation finished without failures"
